//--- rtl/accel_log_pkg.sv
// shared constants for the accelerometer logger
// host register map, host command codes and the control bit layout
// imported by the ring, the host slave and the top level

package accel_log_pkg;

  // host register address, sent MSB first after the command byte
  localparam int ADDR_BITS = 32;

  // region select lives in the top address byte
  localparam logic [7:0] REGION_RAM  = 8'h00; // ring memory, offset in low bits
  localparam logic [7:0] REGION_PTR  = 8'h01; // latched write pointer, bit 0 picks the byte
  localparam logic [7:0] REGION_CTRL = 8'hFF; // control byte

  // first byte of every host transaction
  localparam logic [7:0] HOST_CMD_WRITE = 8'h00;
  localparam logic [7:0] HOST_CMD_READ  = 8'h01;

  // control byte bit positions
  localparam int CTRL_RUN_BIT = 0; // sample reader enable

endpackage

//--- rtl/sample_reader.sv
// SPI master that reads one sensor burst for every drdy rising edge
// mode 0, MSB first; the command byte goes out first, the rest is clocked in
// two of every three received bytes are kept and presented as write strobes

module sample_reader #(
  parameter int unsigned sclk_half = 2,     // system clocks per half SCLK period
  parameter int unsigned burst_len = 10,    // bytes per transaction, command included
  parameter logic [7:0]  read_cmd  = 8'h11  // sensor command byte
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       drdy,
  input  logic       run_en,
  output logic       sensor_csn,
  output logic       sensor_sclk,
  output logic       sensor_mosi,
  input  logic       sensor_miso,
  output logic       wr_stb,
  output logic [7:0] wr_data
);

  localparam int DIV_W  = (sclk_half > 1) ? $clog2(sclk_half) : 1;
  localparam int BYTE_W = (burst_len > 1) ? $clog2(burst_len) : 1;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SHIFT = 2'd1;
  localparam logic [1:0] ST_TAIL  = 2'd2; // last half period before csn rises

  logic [2:0]        drdy_sync;   // two sync flops plus one for edge history
  logic              drdy_rise;
  logic [1:0]        state;
  logic [DIV_W-1:0]  div_cnt;     // half period divider
  logic [2:0]        bit_cnt;
  logic [BYTE_W-1:0] byte_cnt;
  logic [1:0]        keep_phase;  // 0,1 keep  2 drop
  logic [7:0]        tx_sr;
  logic [7:0]        rx_sr;
  logic              half_tick;
  logic              rise_tick;
  logic              fall_tick;
  logic              byte_end;
  logic              keep_byte;

  assign drdy_rise   = drdy_sync[1] & ~drdy_sync[2];
  assign half_tick   = (div_cnt == DIV_W'(sclk_half - 1));
  assign rise_tick   = (state == ST_SHIFT) && half_tick && !sensor_sclk;
  assign fall_tick   = (state == ST_SHIFT) && half_tick && sensor_sclk;
  assign byte_end    = fall_tick && (bit_cnt == 3'd7);
  // byte 0 is the command slot, nothing useful comes back there
  assign keep_byte   = byte_end && (byte_cnt != '0) && (keep_phase != 2'd2);
  assign sensor_mosi = tx_sr[7];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      drdy_sync   <= '0;
      state       <= ST_IDLE;
      sensor_csn  <= 1'b1;
      sensor_sclk <= 1'b0;
      tx_sr       <= '0;
      div_cnt     <= '0;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      keep_phase  <= '0;
      wr_stb      <= 1'b0;
    end
    else
    begin
      drdy_sync <= {drdy_sync[1:0], drdy};
      wr_stb    <= keep_byte; // one cycle after the byte ends
      case (state)
        ST_IDLE:
        begin
          if (drdy_rise && run_en) // edges while busy never get here
          begin
            state      <= ST_SHIFT;
            sensor_csn <= 1'b0;
            tx_sr      <= read_cmd; // MSB on mosi as csn falls
            div_cnt    <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            keep_phase <= '0;
          end
        end
        ST_SHIFT:
        begin
          if (half_tick)
          begin
            div_cnt     <= '0;
            sensor_sclk <= ~sensor_sclk;
            if (sensor_sclk) // falling edge, move to next bit
            begin
              tx_sr   <= {tx_sr[6:0], 1'b0}; // zeros after the command
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7)
              begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt != '0)
                  keep_phase <= (keep_phase == 2'd2) ? 2'd0 : keep_phase + 2'd1;
                if (byte_cnt == BYTE_W'(burst_len - 1))
                  state <= ST_TAIL;
              end
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        ST_TAIL:
        begin
          if (half_tick)
          begin
            div_cnt    <= '0;
            sensor_csn <= 1'b1; // half period after the last bit
            state      <= ST_IDLE;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // receive shifter and output byte
  always_ff @(posedge clk)
  begin
    if (rise_tick)
      rx_sr <= {rx_sr[6:0], sensor_miso}; // sample on rising sclk
    if (keep_byte)
      wr_data <= rx_sr;
  end

  // the ring only sees bytes from inside a sensor frame
  a_stb_in_frame: assert property (@(posedge clk) disable iff (rst)
    wr_stb |-> !sensor_csn);

endmodule

//--- rtl/sample_ring.sv
// circular byte buffer between the sample reader and the host slave
// writes land at the write pointer with address bit 0 flipped, so words are low byte first
// host reads go through a one cycle registered port, decoded by region

module sample_ring
  import accel_log_pkg::*;
#(
  parameter int unsigned ram_len = 6144 // bytes, even
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_stb,
  input  logic [7:0]           wr_data,
  input  logic                 rd_stb,
  input  logic [ADDR_BITS-1:0] rd_addr,
  output logic [7:0]           rd_data
);

  localparam int PTR_W = $clog2(ram_len);
  localparam logic [PTR_W:0] RAM_END = (PTR_W + 1)'(ram_len);

  logic [7:0]       mem [ram_len];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] ptr_latch;  // copy taken on a low byte read
  logic [PTR_W-1:0] ram_off;
  logic [15:0]      ptr_now;
  logic [15:0]      ptr_held;
  logic [7:0]       region;
  logic             ptr_lo_rd;

  assign region    = rd_addr[ADDR_BITS-1 -: 8];
  assign ram_off   = rd_addr[PTR_W-1:0];
  assign ptr_now   = 16'(wr_ptr);
  assign ptr_held  = 16'(ptr_latch);
  assign ptr_lo_rd = rd_stb && (region == REGION_PTR) && !rd_addr[0];

  // pair swap on write
  always_ff @(posedge clk)
  begin
    if (wr_stb)
      mem[wr_ptr ^ PTR_W'(1)] <= wr_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr    <= '0;
      ptr_latch <= '0;
    end
    else
    begin
      if (wr_stb)
      begin
        if (wr_ptr == PTR_W'(ram_len - 1)) // wrap, oldest data gets overwritten
          wr_ptr <= '0;
        else
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (ptr_lo_rd)
        ptr_latch <= wr_ptr; // high byte read later comes from here
    end
  end

  // read port, held between strobes
  always_ff @(posedge clk)
  begin
    if (rd_stb)
    begin
      if (region == REGION_RAM)
        rd_data <= ({1'b0, ram_off} < RAM_END) ? mem[ram_off] : 8'h00;
      else if (region == REGION_PTR)
        rd_data <= rd_addr[0] ? ptr_held[15:8] : ptr_now[7:0];
      else
        rd_data <= 8'h00; // control and unused regions
    end
  end

  a_ptr_range: assert property (@(posedge clk) disable iff (rst)
    {1'b0, wr_ptr} < RAM_END);

endmodule

//--- rtl/host_spi_slave.sv
// host facing SPI slave, mode 0, sampled with the system clock
// frame is a command byte, a 32-bit address MSB first, then data bytes
// reads fetch from the ring ahead of each byte, writes only reach the control byte

module host_spi_slave
  import accel_log_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 host_csn,
  input  logic                 host_sclk,
  input  logic                 host_mosi,
  output logic                 host_miso,
  output logic                 rd_stb,
  output logic [ADDR_BITS-1:0] rd_addr,
  input  logic [7:0]           rd_data,
  output logic                 run_en
);

  localparam logic [2:0] BYTE_ADDR_LAST = 3'd4;
  localparam logic [2:0] BYTE_DATA      = 3'd5; // saturates here

  logic [1:0] csn_sync;
  logic [2:0] sclk_sync;  // extra stage for edge detect
  logic [1:0] mosi_sync;
  logic       active;
  logic       sclk_rise;
  logic       sclk_fall;
  logic [2:0] bit_cnt;
  logic [2:0] byte_idx;   // 0 cmd, 1..4 address, 5 data
  logic [7:0] rx_sr;
  logic [7:0] rx_byte;
  logic [7:0] cmd;
  logic [7:0] tx_sr;
  logic [7:0] ctrl;
  logic       byte_done;
  logic       in_data;
  logic       is_read;

  assign active    = ~csn_sync[1];
  assign sclk_rise = active & sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = active & ~sclk_sync[1] & sclk_sync[2];
  assign rx_byte   = {rx_sr[6:0], mosi_sync[1]}; // byte including the bit on this edge
  assign byte_done = sclk_rise && (bit_cnt == 3'd7);
  assign in_data   = (byte_idx == BYTE_DATA);
  assign is_read   = (cmd == HOST_CMD_READ);
  assign run_en    = ctrl[CTRL_RUN_BIT];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csn_sync  <= 2'b11;
      sclk_sync <= '0;
      mosi_sync <= '0;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      cmd       <= '0;
      tx_sr     <= '0;
      host_miso <= 1'b0;
      rd_stb    <= 1'b0;
      ctrl      <= '0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], host_csn};
      sclk_sync <= {sclk_sync[1:0], host_sclk};
      mosi_sync <= {mosi_sync[0], host_mosi};
      rd_stb    <= 1'b0;
      if (!active)
      begin
        bit_cnt   <= '0; // new frame starts at the command byte
        byte_idx  <= '0;
        host_miso <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
          bit_cnt <= bit_cnt + 3'd1;
        if (byte_done)
        begin
          if (!in_data)
            byte_idx <= byte_idx + 3'd1;
          if (byte_idx == 3'd0)
            cmd <= rx_byte;
          if (byte_idx == BYTE_ADDR_LAST && is_read)
            rd_stb <= 1'b1; // prefetch the first data byte
          if (in_data)
          begin
            if (is_read)
              rd_stb <= 1'b1; // next byte, address already bumped
            else if (cmd == HOST_CMD_WRITE && rd_addr[ADDR_BITS-1 -: 8] == REGION_CTRL)
              ctrl <= rx_byte;
          end
        end
        if (sclk_fall) // miso moves on falling edges
        begin
          if (bit_cnt == 3'd0 && in_data && is_read)
          begin
            host_miso <= rd_data[7];
            tx_sr     <= {rd_data[6:0], 1'b0};
          end
          else
          begin
            host_miso <= tx_sr[7];
            tx_sr     <= {tx_sr[6:0], 1'b0};
          end
        end
      end
    end
  end

  // receive shifter and address collection
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      rx_sr <= rx_byte;
    if (byte_done && byte_idx != 3'd0 && !in_data)
      rd_addr <= {rd_addr[ADDR_BITS-9:0], rx_byte}; // address bytes MSB first
    else if (byte_done && in_data)
      rd_addr <= rd_addr + 1'b1; // auto increment per data byte
  end

  // host must keep csn low for a few clocks after its last sclk edge
  a_rd_in_frame: assert property (@(posedge clk) disable iff (rst)
    rd_stb |-> !host_csn);

endmodule

//--- rtl/accel_log_top.sv
// accelerometer logger top level
// sensor burst reader feeds the ring, the host reads it back over SPI
// parameters set here reach the reader and the ring

module accel_log_top
  import accel_log_pkg::*;
#(
  parameter int unsigned sclk_half = 2,
  parameter int unsigned burst_len = 10,
  parameter logic [7:0]  read_cmd  = 8'h11, // multi-byte axis read
  parameter int unsigned ram_len   = 6144
) (
  input  logic clk,
  input  logic rst,
  input  logic drdy,
  output logic sensor_csn,
  output logic sensor_sclk,
  output logic sensor_mosi,
  input  logic sensor_miso,
  input  logic host_csn,
  input  logic host_sclk,
  input  logic host_mosi,
  output logic host_miso
);

  logic                 run_en;   // control bit from host
  logic                 wr_stb;
  logic [7:0]           wr_data;
  logic                 rd_stb;
  logic [ADDR_BITS-1:0] rd_addr;
  logic [7:0]           rd_data;

  // producer
  sample_reader #(
    .sclk_half (sclk_half),
    .burst_len (burst_len),
    .read_cmd  (read_cmd)
  ) reader_i (
    .clk         (clk),
    .rst         (rst),
    .drdy        (drdy),
    .run_en      (run_en),
    .sensor_csn  (sensor_csn),
    .sensor_sclk (sensor_sclk),
    .sensor_mosi (sensor_mosi),
    .sensor_miso (sensor_miso),
    .wr_stb      (wr_stb),
    .wr_data     (wr_data)
  );

  sample_ring #(
    .ram_len (ram_len)
  ) ring_i (
    .clk     (clk),
    .rst     (rst),
    .wr_stb  (wr_stb),
    .wr_data (wr_data),
    .rd_stb  (rd_stb),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // consumer
  host_spi_slave host_i (
    .clk       (clk),
    .rst       (rst),
    .host_csn  (host_csn),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_miso (host_miso),
    .rd_stb    (rd_stb),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .run_en    (run_en)
  );

endmodule

//--- bench/sensor_model.sv
// SPI slave model of the accelerometer, mode 0, MSB first
// records the command byte and byte count of every frame
// data slots return seeded random bytes, also queued for the testbench model

module sensor_model (
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] data_q [$]; // bytes sent in data slots, oldest first
  logic [7:0] cmd_q [$];  // one command byte per frame
  int         len_q [$];  // whole bytes clocked per frame

  integer     seed;
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;
  logic [7:0] cmd_rx;
  int         bit_cnt;    // rising edges seen in the current byte
  int         byte_cnt;

  initial
  begin
    seed    = 32'h9f2c;
    miso    = 1'b0;
    rx_byte = 8'h00;
    cmd_rx  = 8'h00;
    forever
    begin
      @(negedge csn);
      bit_cnt  = 0;
      byte_cnt = 0;
      tx_byte  = 8'h00; // command slot, sensor has nothing to say yet
      miso    <= 1'b0;
      while (csn === 1'b0)
      begin
        @(posedge sclk or negedge sclk or posedge csn);
        if (csn === 1'b1)
        begin
          // frame closed
          cmd_q.push_back(cmd_rx);
          len_q.push_back(byte_cnt);
        end
        else if (sclk)
        begin
          rx_byte = {rx_byte[6:0], mosi}; // sample on the rising edge
          bit_cnt = bit_cnt + 1;
          if (bit_cnt == 8)
          begin
            if (byte_cnt == 0)
              cmd_rx = rx_byte;
            else
              data_q.push_back(tx_byte); // the reader has all 8 bits now
            byte_cnt = byte_cnt + 1;
            bit_cnt  = 0;
          end
        end
        else if (bit_cnt == 0)
        begin
          tx_byte = 8'($random(seed)); // next slot, MSB goes out right away
          miso   <= tx_byte[7];
        end
        else
          miso <= tx_byte[7 - bit_cnt]; // shift on the falling edge
      end
    end
  end

endmodule

//--- bench/accel_log_tb.sv
// testbench for the accelerometer logger top level
// drdy bursts go to a random sensor model, the ring is read back over host SPI
// expected ring bytes come from the keep/drop rule and the pair swap

module accel_log_tb
  import accel_log_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         SCLK_HALF  = 2;
  localparam int         BURST_LEN  = 10;
  localparam logic [7:0] READ_CMD   = 8'h11;
  localparam int         RAM_LEN    = 48;  // small ring, wraps after 8 bursts
  localparam int         CLK_PERIOD = 8;
  localparam int         HOST_HALF  = 8;   // host sclk half period in clocks
  localparam int         N_BURSTS   = 12;
  localparam int BURST_CLKS = 3 + BURST_LEN * 16 * SCLK_HALF + SCLK_HALF; // edge to csn high
  localparam int SLOT_CLKS  = BURST_CLKS + 300;                           // plus gaps
  localparam int FRAME_CLKS = (5 + RAM_LEN) * 16 * HOST_HALF + 4 * HOST_HALF;
  localparam int WATCHDOG_CLKS = N_BURSTS * SLOT_CLKS + 8 * FRAME_CLKS + 4 * BURST_CLKS + 2000;

  logic clk;
  logic rst;
  logic drdy;
  logic sensor_csn;
  logic sensor_sclk;
  logic sensor_mosi;
  logic sensor_miso;
  logic host_csn;
  logic host_sclk;
  logic host_mosi;
  logic host_miso;

  integer     tb_seed = 32'h9f2c;
  logic [7:0] exp_mem [RAM_LEN];   // ring model
  logic       exp_valid [RAM_LEN]; // unwritten bytes are not compared
  logic [7:0] rd_buf [RAM_LEN];
  int         wr_count   = 0;
  int         txn_count  = 0;      // frames seen by the sensor model
  int         edges_sent = 0;      // drdy edges sent while the reader was idle
  int         csn_falls  = 0;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(negedge sensor_csn) csn_falls++;

  accel_log_top #(
    .sclk_half (SCLK_HALF),
    .burst_len (BURST_LEN),
    .read_cmd  (READ_CMD),
    .ram_len   (RAM_LEN)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .drdy        (drdy),
    .sensor_csn  (sensor_csn),
    .sensor_sclk (sensor_sclk),
    .sensor_mosi (sensor_mosi),
    .sensor_miso (sensor_miso),
    .host_csn    (host_csn),
    .host_sclk   (host_sclk),
    .host_mosi   (host_mosi),
    .host_miso   (host_miso)
  );

  sensor_model sensor_i (
    .csn  (sensor_csn),
    .sclk (sensor_sclk),
    .mosi (sensor_mosi),
    .miso (sensor_miso)
  );

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
    stop_run($sformatf("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want));
  endtask

  function automatic int pick_below(input int n);
    return int'($unsigned($random(tb_seed)) % n);
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one host byte, mode 0, miso read just before the rising edge
  task automatic host_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      host_mosi <= tx[i];
      wait_clks(HOST_HALF);
      rx[i] = host_miso; // settled a few clocks after the last fall
      host_sclk <= 1'b1;
      wait_clks(HOST_HALF);
      host_sclk <= 1'b0;
    end
  endtask

  task automatic host_open(input logic [7:0] cmd, input logic [31:0] addr);
    logic [7:0] junk;
    @(posedge clk);
    host_csn <= 1'b0;
    wait_clks(HOST_HALF);
    host_byte(cmd, junk);
    for (int i = 3; i >= 0; i--)
      host_byte(addr[8*i +: 8], junk); // address MSB first
  endtask

  task automatic host_close();
    wait_clks(HOST_HALF);
    host_csn <= 1'b1;
    wait_clks(2 * HOST_HALF);
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [7:0] data);
    logic [7:0] junk;
    host_open(HOST_CMD_WRITE, addr);
    host_byte(data, junk);
    host_close();
  endtask

  task automatic host_read(input logic [31:0] addr, input int n);
    logic [7:0] got;
    host_open(HOST_CMD_READ, addr);
    for (int i = 0; i < n; i++)
    begin
      host_byte(8'h00, got);
      rd_buf[i] = got;
    end
    host_close();
  endtask

  // pull finished frames out of the sensor model into the ring model
  task automatic absorb_transactions();
    logic [7:0] cmd;
    logic [7:0] b;
    int         len;
    int         slot;
    while (sensor_i.cmd_q.size() > 0)
    begin
      cmd = sensor_i.cmd_q.pop_front();
      len = sensor_i.len_q.pop_front();
      txn_count++;
      assert (cmd == READ_CMD) else value_error("sensor_mosi command", cmd, READ_CMD);
      assert (len == BURST_LEN) else value_error("sensor frame bytes", len, BURST_LEN);
      for (int k = 0; k < len - 1; k++)
      begin
        b = sensor_i.data_q.pop_front();
        if (k % 3 != 2) // third byte of each axis is dropped
        begin
          slot = (wr_count % RAM_LEN) ^ 1; // pair swap
          exp_mem[slot]   = b;
          exp_valid[slot] = 1'b1;
          wr_count++;
        end
      end
    end
  endtask

  task automatic wait_csn_high();
    int waited;
    waited = 0;
    while (sensor_csn !== 1'b1)
    begin
      @(negedge clk);
      waited++;
      if (waited > BURST_CLKS)
        stop_run($sformatf("ERROR at %0t ns: sensor burst did not end in time", $time));
    end
  endtask

  // one accepted edge, then 0 to 2 edges that land inside the burst
  task automatic run_burst();
    int   lag;
    int   extra;
    logic csn_now;
    @(posedge clk);
    drdy <= 1'b1;
    edges_sent++;
    lag     = 0;
    csn_now = 1'b1;
    while (csn_now && lag < 10)
    begin
      @(posedge clk);
      lag++;
      @(negedge clk);
      csn_now = sensor_csn;
    end
    assert (lag == 3) else value_error("sensor_csn fall delay", lag, 3);
    @(posedge clk);
    drdy <= 1'b0;
    extra = pick_below(3);
    for (int i = 0; i < extra; i++)
    begin
      wait_clks(20 + pick_below(40));
      drdy <= 1'b1;
      wait_clks(4);
      drdy <= 1'b0;
    end
    wait_csn_high();
    absorb_transactions();
    assert (txn_count == edges_sent) else value_error("sensor frames", txn_count, edges_sent);
    assert (csn_falls == edges_sent) else value_error("sensor_csn falls", csn_falls, edges_sent);
    wait_clks(20 + pick_below(40));
  endtask

  // drdy edges while the reader is disabled
  task automatic idle_pulses(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      drdy <= 1'b1;
      wait_clks(4);
      drdy <= 1'b0;
      wait_clks(40 + pick_below(40));
    end
    wait_clks(BURST_CLKS); // room for a burst that must not start
    absorb_transactions();
    assert (csn_falls == edges_sent)
    else stop_run($sformatf("ERROR at %0t ns: sensor frame started while disabled", $time));
    assert (txn_count == edges_sent) else value_error("sensor frames", txn_count, edges_sent);
  endtask

  task automatic check_ring();
    logic [15:0] ptr;
    host_read({REGION_RAM, 24'h0}, RAM_LEN);
    for (int i = 0; i < RAM_LEN; i++)
      if (exp_valid[i])
        assert (rd_buf[i] === exp_mem[i])
        else value_error($sformatf("host_miso ring[%0d]", i), rd_buf[i], exp_mem[i]);
    host_read({REGION_PTR, 24'h0}, 2); // low byte read latches the high byte
    ptr = 16'(wr_count % RAM_LEN);
    assert (rd_buf[0] === ptr[7:0]) else value_error("host_miso ptr low", rd_buf[0], ptr[7:0]);
    assert (rd_buf[1] === ptr[15:8]) else value_error("host_miso ptr high", rd_buf[1], ptr[15:8]);
  endtask

  initial
  begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    stop_run("ERROR: watchdog expired before the test sequence finished");
  end

  initial
  begin
    for (int i = 0; i < RAM_LEN; i++)
      exp_valid[i] = 1'b0;
    rst       = 1'b1;
    drdy      = 1'b0;
    host_csn  = 1'b1;
    host_sclk = 1'b0;
    host_mosi = 1'b0;
    wait_clks(10);
    rst <= 1'b0;
    wait_clks(4);
    idle_pulses(3);                            // run bit still clear
    host_write({REGION_CTRL, 24'h0}, 8'h01);
    for (int b = 0; b < 4; b++)
      run_burst();
    check_ring();                              // before the wrap
    for (int b = 4; b < N_BURSTS; b++)
      run_burst();
    check_ring();                              // newest bytes over the oldest
    host_write({REGION_CTRL, 24'h0}, 8'h00);
    idle_pulses(3);
    check_ring();                              // nothing moved after stop
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- src.f
rtl/accel_log_pkg.sv
rtl/sample_reader.sv
rtl/sample_ring.sv
rtl/host_spi_slave.sv
rtl/accel_log_top.sv
bench/sensor_model.sv
bench/accel_log_tb.sv

//--- Makefile
# Verilator build and run for the accelerometer logger testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= accel_log_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
